//--- list.f
cnnPkg.sv
featureMem.sv
layerSequencer.sv
convEngine.sv
poolEngine.sv
fcEngine.sv
cnnAccel.sv
tbClock.sv
cnnAccel_asserts.sv
cnnAccel_tb.sv

//--- Makefile
SRCS := $(shell cat list.f)

.PHONY: run clean

obj_dir/VcnnAccel_tb: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module cnnAccel_tb -f list.f

run: obj_dir/VcnnAccel_tb
	./obj_dir/VcnnAccel_tb | awk '{ print } /Done: no errors/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- cnnAccel_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cnnAccel_tb;
    import cnnPkg::*;

    localparam int RUN_CYCLES  = 600;   // generous bound on one inference
    localparam int TOTAL_RUNS  = 8;
    localparam int WATCHDOG_NS = (16 + TOTAL_RUNS * (RUN_CYCLES + 40)) * 10;

    localparam layerT SCHEDULE [12] = '{
        CONV1, POOL1, CONV2, POOL2, CONV3, CONV4, CONV5, POOL5, FC6, FC7, FC8, IDLE
    };

    logic                 clk;
    logic                 rst;
    logic                 dataReady;
    logic                 hostWrEn;
    logic [3:0]           hostAddr;
    logic [DATA_W-1:0]    hostWrData;
    logic [DATA_W-1:0]    hostRdData;
    logic                 busy;
    logic                 netDone;
    layerT                runLayer;

    logic signed [15:0]   inVec [16];    // vector loaded by the host
    logic [15:0]          expect0;
    logic [15:0]          expect1;
    logic [15:0]          res0;
    logic [15:0]          res1;
    layerT                layerLog [$];
    integer               seed = 32'hb9ab7d48;
    int                   errorCount = 0;
    int                   checkCount = 0;

    tbClock #(.PeriodNs(10), .ResetCycles(16)) uClk (.clk, .rst);

    cnnAccel #(.DataW(DATA_W), .VecLen(VEC_LEN), .MemDepth(MEM_DEPTH)) dut (
        .clk, .rst, .dataReady, .hostWrEn, .hostAddr, .hostWrData,
        .hostRdData, .busy, .netDone, .runLayer
    );

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            errorCount++;
        end
    endtask

    // eleven layers straight from the kernel tables
    task automatic runModel();
        logic signed [15:0]      cur [16];
        logic signed [15:0]      nxt [16];
        logic signed [ACC_W-1:0] acc;
        int                      len;
        int                      p;
        layerT                   l;
        cur = inVec;
        for (int n = 1; n <= 11; n++) begin
            l   = layerT'(n);
            len = LAYER_LEN[n];
            nxt = cur;
            case (l)
                CONV1, CONV2, CONV3, CONV4, CONV5: begin
                    for (int i = 0; i < len; i++) begin
                        acc = KERNEL_B[n][0];
                        for (int t = 0; t < 3; t++) begin
                            p = i + t - 1;                // tap 0 looks left
                            if (p >= 0 && p < len) begin
                                acc = acc + KERNEL_W[n][t] * cur[p];
                            end
                        end
                        nxt[i] = clipRelu(acc);
                    end
                end
                POOL1, POOL2, POOL5: begin
                    for (int k = 0; k < len / 2; k++) begin
                        nxt[k] = (cur[2*k] > cur[2*k+1]) ? cur[2*k] : cur[2*k+1];
                    end
                end
                default: begin
                    for (int j = 0; j < 2; j++) begin
                        acc = KERNEL_B[n][j];
                        for (int i = 0; i < 2; i++) begin
                            acc = acc + KERNEL_W[n][2*j+i] * cur[i];
                        end
                        nxt[j] = clipRelu(acc);
                    end
                end
            endcase
            cur = nxt;
        end
        expect0 = cur[0];
        expect1 = cur[1];
    endtask

    task automatic loadVector();
        for (int a = 0; a < 16; a++) begin
            hostWrEn   = 1'b1;
            hostAddr   = 4'(a);
            hostWrData = inVec[a];
            @(posedge clk);
            #1;
        end
        hostWrEn = 1'b0;
    endtask

    // one inference, optionally with host writes while busy
    task automatic runNetwork(input bit writeWhileBusy);
        int    cycles;
        int    busyLow;
        bit    finished;
        layerT lastLayer;
        lastLayer = IDLE;
        finished  = 1'b0;
        cycles    = 0;
        busyLow   = 0;
        layerLog.delete();
        dataReady = 1'b1;
        while (!finished && cycles < RUN_CYCLES) begin
            @(posedge clk);
            #1;
            dataReady = 1'b0;
            cycles++;
            if (runLayer != lastLayer) begin
                layerLog.push_back(runLayer);
                lastLayer = runLayer;
            end
            if (!netDone && !busy) begin
                busyLow++;
            end
            if (writeWhileBusy && cycles < 20) begin
                hostWrEn   = 1'b1;
                hostAddr   = 4'(cycles);
                hostWrData = 16'($random(seed));
            end else begin
                hostWrEn = 1'b0;
            end
            finished = netDone;
        end
        hostWrEn = 1'b0;
        checkCount++;
        assert (finished) else begin
            $display("netDone never arrived within %0d cycles", RUN_CYCLES);
            errorCount++;
        end
        checkValue("busy low cycles during run", 16'(busyLow), 16'h0);
        checkValue("busy at netDone", 16'(busy), 16'h0);
    endtask

    task automatic readResults();
        hostAddr = 4'd0;
        @(posedge clk);
        #1;
        res0     = hostRdData;
        checkValue("netDone after pulse", 16'(netDone), 16'h0);
        hostAddr = 4'd1;
        @(posedge clk);
        #1;
        res1 = hostRdData;
    endtask

    task automatic runAndCheck(input string tag, input bit writeWhileBusy);
        loadVector();
        runNetwork(writeWhileBusy);
        readResults();
        runModel();
        checkValue({tag, " hostRdData[0]"}, res0, expect0);
        checkValue({tag, " hostRdData[1]"}, res1, expect1);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic checkResetState();
        checkValue("busy", 16'(busy), 16'h0);
        checkValue("netDone", 16'(netDone), 16'h0);
        checkValue("runLayer", 16'(runLayer), 16'(IDLE));
    endtask

    task automatic testFixedVector();
        inVec = '{100, 250, -40, 75, 310, 5, -120, 60, 420, 90, 15, -3, 200, 180, 33, 7};
        runAndCheck("fixed", 1'b0);
    endtask

    task automatic testRandomVectors();
        int rnd;
        for (int v = 0; v < 4; v++) begin
            for (int a = 0; a < 16; a++) begin
                rnd      = $random(seed);
                inVec[a] = $signed(rnd[15:0]) >>> 4;  // keep most sums unclipped
            end
            runAndCheck($sformatf("random%0d", v), 1'b0);
        end
    endtask

    task automatic testLayerOrder();
        inVec = '{9, 8, 7, 6, 5, 4, 3, 2, 1, 2, 3, 4, 5, 6, 7, 8};
        runAndCheck("order", 1'b0);
        checkValue("runLayer change count", 16'(layerLog.size()), 16'd12);
        for (int i = 0; i < 12 && i < layerLog.size(); i++) begin
            checkValue($sformatf("runLayer step %0d", i), 16'(layerLog[i]),
                       16'(SCHEDULE[i]));
        end
    endtask

    task automatic testWritesWhileBusy();
        inVec = '{12, -7, 44, 3, 90, 61, -25, 8, 17, 70, 5, 33, -1, 28, 52, 11};
        runAndCheck("busy writes", 1'b1);
    endtask

    task automatic testClipping();
        inVec = '{32767, -32768, 30000, -30000, 32767, 32767, -20000, 25000,
                  -32768, 32000, 31000, -5, 32767, -32768, 28000, 32767};
        runAndCheck("clip", 1'b0);
        checkValue("clip hostRdData[0] sign", 16'(res0[15]), 16'h0);
        checkValue("clip hostRdData[1] sign", 16'(res1[15]), 16'h0);
    endtask

    initial begin
        dataReady  = 1'b0;
        hostWrEn   = 1'b0;
        hostAddr   = '0;
        hostWrData = '0;
        wait (!rst);
        @(posedge clk);
        #1;
        checkResetState();
        testFixedVector();
        testRandomVectors();
        testLayerOrder();
        testWritesWhileBusy();
        testClipping();
        $display("errors: %0d of %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: simulation still running after %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- cnnAccel_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module cnnAccel_asserts (
    input wire                clk,
    input wire                rst,
    input wire cnnPkg::layerT runLayer,
    input wire                convStart,
    input wire                poolStart,
    input wire                fcStart,
    input wire                busy,
    input wire                netDone
);
    import cnnPkg::*;

    logic anyStart;

    assign anyStart = convStart || poolStart || fcStart;

    startOneHot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({convStart, poolStart, fcStart}))
        else $error("more than one engine start pulse in a cycle");

    startSingleCycle: assert property (@(posedge clk) disable iff (rst)
        anyStart |=> !anyStart)
        else $error("engine start pulse held longer than one cycle");

    // end of run only out of the last layer
    doneLeavesFc8: assert property (@(posedge clk) disable iff (rst)
        netDone |-> $past(runLayer) == FC8 && runLayer == IDLE)
        else $error("netDone without leaving FC8");

    // busy only ends together with the run
    busyEndsWithDone: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> netDone)
        else $error("busy dropped without netDone");

endmodule

bind layerSequencer cnnAccel_asserts uSeqAsserts (.*);

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
    parameter int PeriodNs    = 10,
    parameter int ResetCycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = !clk;
    end

    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1 rst = 1'b0;                  // release off the edge
    end

endmodule

`default_nettype wire

//--- cnnAccel.sv
`timescale 1ns/10ps
`default_nettype none

module cnnAccel #(
    parameter int DataW    = cnnPkg::DATA_W,
    parameter int VecLen   = cnnPkg::VEC_LEN,
    parameter int MemDepth = cnnPkg::MEM_DEPTH
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         dataReady,
    input  wire                         hostWrEn,
    input  wire  [$clog2(MemDepth)-1:0] hostAddr,
    input  wire  [DataW-1:0]            hostWrData,
    output logic [DataW-1:0]            hostRdData,
    output logic                        busy,
    output logic                        netDone,
    output cnnPkg::layerT               runLayer
);
    import cnnPkg::*;

    localparam int AddrW = $clog2(MemDepth);

    //////////////////////////////
    // sequencer strobes
    //////////////////////////////
    logic convStart;
    logic poolStart;
    logic fcStart;
    logic kernelReadEn;
    logic bankSwap;
    logic netStart;
    logic convDone;
    logic poolDone;
    logic fcDone;

    //////////////////////////////
    // engine memory ports
    //////////////////////////////
    logic [DataW-1:0] engRdData;
    logic [AddrW-1:0] convRdAddr;
    logic [AddrW-1:0] convWrAddr;
    logic [DataW-1:0] convWrData;
    logic             convWrEn;
    logic [AddrW-1:0] poolRdAddr;
    logic [AddrW-1:0] poolWrAddr;
    logic [DataW-1:0] poolWrData;
    logic             poolWrEn;
    logic [AddrW-1:0] fcRdAddr;
    logic [AddrW-1:0] fcWrAddr;
    logic [DataW-1:0] fcWrData;
    logic             fcWrEn;

    assign netStart = convStart && (runLayer == CONV1);   // first layer of a run

    layerSequencer uSeq (
        .clk, .rst, .dataReady, .convDone, .poolDone, .fcDone,
        .runLayer, .convStart, .poolStart, .fcStart,
        .kernelReadEn, .bankSwap, .busy, .netDone
    );

    featureMem #(.DataW(DataW), .MemDepth(MemDepth)) uMem (
        .clk, .rst, .runLayer, .netStart, .bankSwap,
        .hostWrEn, .hostAddr, .hostWrData, .busy,
        .convRdAddr, .convWrEn, .convWrAddr, .convWrData,
        .poolRdAddr, .poolWrEn, .poolWrAddr, .poolWrData,
        .fcRdAddr, .fcWrEn, .fcWrAddr, .fcWrData,
        .engRdData, .hostRdData
    );

    convEngine #(.DataW(DataW), .VecLen(VecLen), .MemDepth(MemDepth)) uConv (
        .clk, .rst, .runLayer, .start(convStart), .kernelReadEn, .rdData(engRdData),
        .rdAddr(convRdAddr), .wrEn(convWrEn), .wrAddr(convWrAddr),
        .wrData(convWrData), .done(convDone)
    );

    poolEngine #(.DataW(DataW), .VecLen(VecLen), .MemDepth(MemDepth)) uPool (
        .clk, .rst, .runLayer, .start(poolStart), .rdData(engRdData),
        .rdAddr(poolRdAddr), .wrEn(poolWrEn), .wrAddr(poolWrAddr),
        .wrData(poolWrData), .done(poolDone)
    );

    fcEngine #(.DataW(DataW), .MemDepth(MemDepth)) uFc (
        .clk, .rst, .runLayer, .start(fcStart), .kernelReadEn, .rdData(engRdData),
        .rdAddr(fcRdAddr), .wrEn(fcWrEn), .wrAddr(fcWrAddr),
        .wrData(fcWrData), .done(fcDone)
    );

endmodule

`default_nettype wire

//--- fcEngine.sv
`timescale 1ns/10ps
`default_nettype none

module fcEngine #(
    parameter int DataW    = cnnPkg::DATA_W,
    parameter int MemDepth = cnnPkg::MEM_DEPTH
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire cnnPkg::layerT          runLayer,
    input  wire                         start,
    input  wire                         kernelReadEn,
    input  wire  [DataW-1:0]            rdData,
    output logic [$clog2(MemDepth)-1:0] rdAddr,
    output logic                        wrEn,
    output logic [$clog2(MemDepth)-1:0] wrAddr,
    output logic [DataW-1:0]            wrData,
    output logic                        done
);
    import cnnPkg::*;

    localparam int AddrW = $clog2(MemDepth);

    typedef enum logic [1:0] {F_IDLE, F_READ, F_WRITE} stateT;

    stateT                   state;
    logic                    inSel;    // input i
    logic                    outSel;   // output j
    logic signed [ACC_W-1:0] acc;
    logic signed [7:0]       weight;
    logic signed [15:0]      bias;

    // weight entry 2j+i
    assign weight = kernelReadEn ? KERNEL_W[runLayer][{outSel, inSel}] : 8'sd0;
    assign bias   = kernelReadEn ? KERNEL_B[runLayer][outSel] : 16'sd0;

    assign rdAddr = AddrW'(inSel);
    assign wrEn   = state == F_WRITE;
    assign wrAddr = AddrW'(outSel);
    assign wrData = DataW'(clipRelu(acc + bias));
    assign done   = wrEn && outSel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= F_IDLE;
            inSel  <= 1'b0;
            outSel <= 1'b0;
        end else begin
            case (state)
                F_IDLE: if (start) begin
                    state  <= F_READ;
                    inSel  <= 1'b0;
                    outSel <= 1'b0;
                end
                F_READ: begin
                    inSel <= !inSel;
                    if (inSel) begin
                        state <= F_WRITE;
                    end
                end
                default: begin
                    state  <= outSel ? F_IDLE : F_READ;
                    outSel <= !outSel;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_READ) begin
            acc <= acc + weight * $signed(rdData);
        end else begin
            acc <= '0;                     // fresh sum per output
        end
    end

endmodule

`default_nettype wire

//--- poolEngine.sv
`timescale 1ns/10ps
`default_nettype none

module poolEngine #(
    parameter int DataW    = cnnPkg::DATA_W,
    parameter int VecLen   = cnnPkg::VEC_LEN,
    parameter int MemDepth = cnnPkg::MEM_DEPTH
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire cnnPkg::layerT          runLayer,
    input  wire                         start,
    input  wire  [DataW-1:0]            rdData,
    output logic [$clog2(MemDepth)-1:0] rdAddr,
    output logic                        wrEn,
    output logic [$clog2(MemDepth)-1:0] wrAddr,
    output logic [DataW-1:0]            wrData,
    output logic                        done
);
    import cnnPkg::*;

    localparam int AddrW = $clog2(MemDepth);
    localparam int IdxW  = $clog2(VecLen);

    typedef enum logic [1:0] {P_IDLE, P_LOW, P_HIGH} stateT;

    stateT            state;
    logic [IdxW-1:0]  k;        // output index
    logic [DataW-1:0] hold;     // element 2k
    logic             lastK;

    assign rdAddr = AddrW'(2 * int'(k) + int'(state == P_HIGH));
    assign lastK  = int'(k) == LAYER_LEN[runLayer] / 2 - 1;
    assign wrEn   = state == P_HIGH;   // second read and write together
    assign wrAddr = AddrW'(k);
    assign wrData = ($signed(rdData) > $signed(hold)) ? rdData : hold;
    assign done   = wrEn && lastK;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= P_IDLE;
            k     <= '0;
        end else begin
            case (state)
                P_IDLE: if (start) begin
                    state <= P_LOW;
                    k     <= '0;
                end
                P_LOW: state <= P_HIGH;
                default: begin
                    state <= lastK ? P_IDLE : P_LOW;
                    k     <= k + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == P_LOW) begin
            hold <= rdData;
        end
    end

endmodule

`default_nettype wire

//--- convEngine.sv
`timescale 1ns/10ps
`default_nettype none

module convEngine #(
    parameter int DataW    = cnnPkg::DATA_W,
    parameter int VecLen   = cnnPkg::VEC_LEN,
    parameter int MemDepth = cnnPkg::MEM_DEPTH
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire cnnPkg::layerT          runLayer,
    input  wire                         start,
    input  wire                         kernelReadEn,
    input  wire  [DataW-1:0]            rdData,
    output logic [$clog2(MemDepth)-1:0] rdAddr,
    output logic                        wrEn,
    output logic [$clog2(MemDepth)-1:0] wrAddr,
    output logic [DataW-1:0]            wrData,
    output logic                        done
);
    import cnnPkg::*;

    localparam int AddrW = $clog2(MemDepth);
    localparam int IdxW  = $clog2(VecLen);

    typedef enum logic [1:0] {C_IDLE, C_READ, C_WRITE} stateT;

    stateT                   state;
    logic [IdxW-1:0]         idx;      // output position
    logic [1:0]              tap;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] prod;
    logic signed [7:0]       tapW;
    logic signed [15:0]      bias;
    int                      pos;
    logic                    lastIdx;

    always_comb begin
        pos  = int'(idx) + int'(tap) - 1;          // tap 0 is left neighbour
        tapW = kernelReadEn ? KERNEL_W[runLayer][tap] : 8'sd0;
        bias = kernelReadEn ? KERNEL_B[runLayer][0] : 16'sd0;
        if (pos >= 0 && pos < LAYER_LEN[runLayer]) begin
            prod = tapW * $signed(rdData);
        end else begin
            prod = '0;                             // zero padding
        end
    end

    assign rdAddr  = AddrW'(pos);
    assign lastIdx = int'(idx) == LAYER_LEN[runLayer] - 1;
    assign wrEn    = state == C_WRITE;
    assign wrAddr  = AddrW'(idx);
    assign wrData  = DataW'(clipRelu(acc + bias));
    assign done    = wrEn && lastIdx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= C_IDLE;
            idx   <= '0;
            tap   <= '0;
        end else begin
            case (state)
                C_IDLE: if (start) begin
                    state <= C_READ;
                    idx   <= '0;
                    tap   <= '0;
                end
                C_READ: begin
                    tap <= (tap == 2'd2) ? 2'd0 : tap + 2'd1;
                    if (tap == 2'd2) begin
                        state <= C_WRITE;
                    end
                end
                default: begin
                    state <= lastIdx ? C_IDLE : C_READ;
                    idx   <= idx + 1'b1;
                end
            endcase
        end
    end

    // cleared outside the read phase
    always_ff @(posedge clk) begin
        acc <= (state == C_READ) ? acc + prod : ACC_W'(0);
    end

endmodule

`default_nettype wire

//--- layerSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module layerSequencer (
    input  wire           clk,
    input  wire           rst,
    input  wire           dataReady,
    input  wire           convDone,
    input  wire           poolDone,
    input  wire           fcDone,
    output cnnPkg::layerT runLayer,
    output logic          convStart,
    output logic          poolStart,
    output logic          fcStart,
    output logic          kernelReadEn,
    output logic          bankSwap,
    output logic          busy,
    output logic          netDone
);
    import cnnPkg::*;

    logic launch;       // layer just entered, start next cycle
    logic layerDone;

    // only the engine owning the layer may end it
    assign layerDone = (isConvLayer(runLayer) && convDone) ||
                       (isPoolLayer(runLayer) && poolDone) ||
                       (isFcLayer(runLayer) && fcDone);

    assign bankSwap     = layerDone;   // output becomes next input
    assign kernelReadEn = isConvLayer(runLayer) || isFcLayer(runLayer);
    assign busy         = runLayer != IDLE;

    //////////////////////////////
    // layer schedule
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            runLayer  <= IDLE;
            launch    <= 1'b0;
            convStart <= 1'b0;
            poolStart <= 1'b0;
            fcStart   <= 1'b0;
            netDone   <= 1'b0;
        end else begin
            convStart <= launch && isConvLayer(runLayer);
            poolStart <= launch && isPoolLayer(runLayer);
            fcStart   <= launch && isFcLayer(runLayer);
            launch    <= 1'b0;
            netDone   <= 1'b0;
            if (runLayer == IDLE) begin
                if (dataReady) begin
                    runLayer <= CONV1;
                    launch   <= 1'b1;
                end
            end else if (layerDone) begin
                if (runLayer == FC8) begin
                    runLayer <= IDLE;      // results now in source bank
                    netDone  <= 1'b1;
                end else begin
                    runLayer <= layerT'(runLayer + 4'd1);
                    launch   <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- featureMem.sv
`timescale 1ns/10ps
`default_nettype none

module featureMem #(
    parameter int DataW    = cnnPkg::DATA_W,
    parameter int MemDepth = cnnPkg::MEM_DEPTH
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire cnnPkg::layerT          runLayer,
    input  wire                         netStart,
    input  wire                         bankSwap,
    input  wire                         hostWrEn,
    input  wire  [$clog2(MemDepth)-1:0] hostAddr,
    input  wire  [DataW-1:0]            hostWrData,
    input  wire                         busy,
    input  wire  [$clog2(MemDepth)-1:0] convRdAddr,
    input  wire                         convWrEn,
    input  wire  [$clog2(MemDepth)-1:0] convWrAddr,
    input  wire  [DataW-1:0]            convWrData,
    input  wire  [$clog2(MemDepth)-1:0] poolRdAddr,
    input  wire                         poolWrEn,
    input  wire  [$clog2(MemDepth)-1:0] poolWrAddr,
    input  wire  [DataW-1:0]            poolWrData,
    input  wire  [$clog2(MemDepth)-1:0] fcRdAddr,
    input  wire                         fcWrEn,
    input  wire  [$clog2(MemDepth)-1:0] fcWrAddr,
    input  wire  [DataW-1:0]            fcWrData,
    output logic [DataW-1:0]            engRdData,
    output logic [DataW-1:0]            hostRdData
);
    import cnnPkg::*;

    localparam int AddrW = $clog2(MemDepth);

    logic [DataW-1:0] mem [2][MemDepth];
    logic             srcSel;              // bank the engines read from
    logic [AddrW-1:0] rdAddr;
    logic [AddrW-1:0] wrAddr;
    logic [DataW-1:0] wrData;
    logic             wrEn;

    // port of the engine class owning the current layer
    always_comb begin
        rdAddr = fcRdAddr;
        wrAddr = fcWrAddr;
        wrData = fcWrData;
        wrEn   = fcWrEn && isFcLayer(runLayer);
        if (isConvLayer(runLayer)) begin
            rdAddr = convRdAddr;
            wrAddr = convWrAddr;
            wrData = convWrData;
            wrEn   = convWrEn;
        end else if (isPoolLayer(runLayer)) begin
            rdAddr = poolRdAddr;
            wrAddr = poolWrAddr;
            wrData = poolWrData;
            wrEn   = poolWrEn;
        end
    end

    assign engRdData  = mem[srcSel][rdAddr];
    assign hostRdData = mem[srcSel][hostAddr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            srcSel <= 1'b0;
        end else if (netStart) begin
            srcSel <= 1'b0;                // host data sits in bank 0
        end else if (bankSwap) begin
            srcSel <= !srcSel;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[!srcSel][wrAddr] <= wrData;
        end
        if (hostWrEn && !busy) begin
            mem[0][hostAddr] <= hostWrData;   // load only between runs
        end
    end

endmodule

`default_nettype wire

//--- cnnPkg.sv
`default_nettype none

package cnnPkg;

    //////////////////////////////
    // sizes
    //////////////////////////////
    localparam int DATA_W    = 16;  // feature element width
    localparam int ACC_W     = 32;  // mac accumulator width
    localparam int VEC_LEN   = 16;  // host input vector
    localparam int MEM_DEPTH = 16;  // words per bank
    localparam int CLIP_MAX  = 2 ** (DATA_W - 1) - 1;

    // controller states, one per layer of the schedule
    typedef enum logic [3:0] {
        IDLE, CONV1, POOL1, CONV2, POOL2, CONV3, CONV4, CONV5, POOL5, FC6, FC7, FC8
    } layerT;

    //////////////////////////////
    // layer tables
    //////////////////////////////
    localparam int LAYER_LEN [12] = '{
        0, VEC_LEN, VEC_LEN, VEC_LEN / 2, VEC_LEN / 2,
        VEC_LEN / 4, VEC_LEN / 4, VEC_LEN / 4, VEC_LEN / 4,
        VEC_LEN / 8, VEC_LEN / 8, VEC_LEN / 8
    };

    // conv: taps 0..2 left to right, fc: entry 2j+i
    localparam logic signed [7:0] KERNEL_W [12][4] = '{
        '{ 0,  0,  0, 0},   // idle
        '{ 1,  2, -1, 0},   // conv1
        '{ 0,  0,  0, 0},   // pool1
        '{-1,  3,  1, 0},   // conv2
        '{ 0,  0,  0, 0},   // pool2
        '{ 2,  1,  1, 0},   // conv3
        '{ 1, -2,  3, 0},   // conv4
        '{ 1,  1,  1, 0},   // conv5
        '{ 0,  0,  0, 0},   // pool5
        '{ 2, -1,  1, 3},   // fc6
        '{ 1,  1, -1, 2},   // fc7
        '{ 3, -2,  1, 1}    // fc8
    };

    localparam logic signed [15:0] KERNEL_B [12][2] = '{
        '{  0,  0}, '{ 16,  0}, '{  0,  0}, '{ -8,  0}, '{  0,  0}, '{  4,  0},
        '{ 32,  0}, '{-16,  0}, '{  0,  0}, '{ 10, -5}, '{  0, 20}, '{  7,  3}
    };

    // relu followed by saturation to the positive half
    function automatic logic [DATA_W-1:0] clipRelu(input logic signed [ACC_W-1:0] acc);
        if (acc < 0) begin
            return '0;
        end else if (acc > CLIP_MAX) begin
            return DATA_W'(CLIP_MAX);
        end
        return acc[DATA_W-1:0];
    endfunction

    function automatic logic isConvLayer(input layerT l);
        return l inside {CONV1, CONV2, CONV3, CONV4, CONV5};
    endfunction

    function automatic logic isPoolLayer(input layerT l);
        return l inside {POOL1, POOL2, POOL5};
    endfunction

    function automatic logic isFcLayer(input layerT l);
        return l inside {FC6, FC7, FC8};
    endfunction

endpackage

`default_nettype wire
